// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 55;
    localparam int LINE_W   = 64;
    localparam int INST_W   = 32;
    localparam int XLEN     = 64;

    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [LINE_W-1:0]           line_t;
    typedef logic [INST_W-1:0]           inst_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    typedef enum logic [3:0] {
        TRAP_NONE          = 4'd0,
        TRAP_TIMER_INT     = 4'd1,
        TRAP_INST_MISALIGN = 4'd2
    } trap_t;

    typedef enum logic [1:0] {
        TYPE_NOP     = 2'd0,  // Decode can take an instruction
        TYPE_FENCE_I = 2'd1,
        TYPE_BUSY    = 2'd2
    } id_type_t;

    localparam logic [31:0] CACHED_BASE  = 32'h8000_0000;
    localparam logic [31:0] CACHED_LIMIT = 32'h8fff_ffff;

    localparam int MTIE_BIT = 7;  // mie
    localparam int MTIP_BIT = 7;  // mip
    localparam int MIE_BIT  = 3;  // mstatus

endpackage

// ==== source/axi_pkg.sv ====
package axi_pkg;

    localparam logic [3:0] FETCH_ID = 4'd0;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    localparam logic [1:0] BURST_FIXED = 2'b00;

    localparam logic [2:0] SIZE_WORD  = 3'd2;  // 4 bytes
    localparam logic [2:0] SIZE_DWORD = 3'd3;  // 8 bytes

endpackage

// ==== source/icache_if.sv ====
interface icache_if;
    import fetch_pkg::*;

    index_t index;
    tag_t   tag;
    logic   word_sel;    // pc[2]
    logic   fill;
    logic   invalidate;
    line_t  fill_line;
    logic   hit;
    way_t   hit_way;
    way_t   fill_way;    // Victim
    inst_t  hit_inst;

    modport ctrl (
        output index, tag, word_sel, fill, invalidate, fill_line,
        input  hit, hit_inst
    );

    modport tags (
        input  index, tag, fill, invalidate,
        output hit, hit_way, fill_way
    );

    modport data (
        input  index, word_sel, fill, fill_line, hit_way, fill_way,
        output hit_inst
    );

endinterface

// ==== source/set_array.sv ====
module set_array #(
    parameter type entry_t = logic [7:0]
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  fetch_pkg::index_t waddr,
    input  entry_t            wdata,
    input  fetch_pkg::index_t raddr,
    output entry_t            rdata
);
    import fetch_pkg::*;

    entry_t mem [NUM_SETS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Lookup path stays combinational
    assign rdata = mem[raddr];

endmodule

// ==== source/icache_tags.sv ====
module icache_tags (
    input logic   clk,
    input logic   rst,
    icache_if.tags cache
);
    import fetch_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] hit_vec;
    tag_t                tag_rd [NUM_WAYS];

    assign set_valid = valid_q[cache.index];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        set_array #(
            .entry_t(tag_t)
        ) u_tag (
            .clk  (clk),
            .rst  (rst),
            .we   (cache.fill && cache.fill_way == way_t'(w)),
            .waddr(cache.index),
            .wdata(cache.tag),
            .raddr(cache.index),
            .rdata(tag_rd[w])
        );

        assign hit_vec[w] = set_valid[w] && (tag_rd[w] == cache.tag);
    end

    // Valid bits kept apart from the tag arrays for a one-cycle flash clear
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (cache.invalidate) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (cache.fill) begin
            valid_q[cache.index][cache.fill_way] <= 1'b1;
        end
    end

    assign cache.hit = |hit_vec;

    always_comb begin
        cache.hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                cache.hit_way = way_t'(w);  // Lowest way wins
            end
        end
    end

    // First invalid way, way 0 when the set is full
    always_comb begin
        cache.fill_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                cache.fill_way = way_t'(w);
            end
        end
    end

endmodule

// ==== source/icache_data.sv ====
module icache_data (
    input logic   clk,
    input logic   rst,
    icache_if.data cache
);
    import fetch_pkg::*;

    line_t line_rd [NUM_WAYS];
    line_t hit_line;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        set_array #(
            .entry_t(line_t)
        ) u_line (
            .clk  (clk),
            .rst  (rst),
            .we   (cache.fill && cache.fill_way == way_t'(w)),
            .waddr(cache.index),
            .wdata(cache.fill_line),
            .raddr(cache.index),
            .rdata(line_rd[w])
        );
    end

    assign hit_line = line_rd[cache.hit_way];

    always_comb begin
        if (cache.word_sel) begin
            cache.hit_inst = hit_line[LINE_W-1:INST_W];  // Upper word
        end else begin
            cache.hit_inst = hit_line[INST_W-1:0];
        end
    end

endmodule

// ==== source/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  fetch_pkg::addr_t           pc,
    input  logic [fetch_pkg::XLEN-1:0] mstatus,
    input  logic [fetch_pkg::XLEN-1:0] mie,
    input  logic [fetch_pkg::XLEN-1:0] mip,
    input  fetch_pkg::id_type_t        id_type,
    input  logic                       id_ready,
    output fetch_pkg::trap_t           trap,
    output logic                       valid_out,
    output logic                       ready,
    output fetch_pkg::inst_t           inst,
    input  logic                       arready,
    output logic                       arvalid,
    output logic [31:0]                araddr,
    output logic [3:0]                 arid,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    output logic                       rready,
    input  logic                       rvalid,
    input  axi_pkg::resp_t             rresp,
    input  fetch_pkg::line_t           rdata,
    input  logic                       rlast,
    input  logic [3:0]                 rid,
    icache_if.ctrl                     cache
);
    import fetch_pkg::*;
    import axi_pkg::*;

    typedef enum logic [2:0] {START, RCACHE, AR, R, FILL, FINISH} state_t;

    state_t state;
    line_t  rbuf;
    logic   cacheable;
    logic   rd_done;
    logic   go;

    assign cacheable = pc[31:0] >= CACHED_BASE && pc[31:0] <= CACHED_LIMIT;
    assign rd_done   = rvalid && rid == FETCH_ID && rlast
                    && (rresp == RESP_OKAY || rresp == RESP_EXOKAY);

    always_comb begin
        trap = TRAP_NONE;
        if (id_type == TYPE_NOP) begin
            if (mie[MTIE_BIT] && mip[MTIP_BIT] && mstatus[MIE_BIT]) begin
                trap = TRAP_TIMER_INT;
            end else if (pc[1:0] != 2'b00) begin
                trap = TRAP_INST_MISALIGN;
            end
        end
    end

    assign go = trap == TRAP_NONE && id_type == TYPE_NOP;  // Real fetch starts

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= START;
        end else begin
            case (state)
                START:   if (go) state <= (cacheable && cache.hit) ? RCACHE : AR;
                RCACHE:  state <= FINISH;
                AR:      if (arready) state <= R;
                R:       if (rd_done) state <= cacheable ? FILL : FINISH;
                FILL:    state <= RCACHE;
                FINISH:  if (id_ready) state <= START;
                default: state <= START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R && rd_done) begin
            rbuf <= rdata;
        end
    end

    assign cache.index      = pc[8:3];
    assign cache.tag        = pc[63:9];
    assign cache.word_sel   = pc[2];
    assign cache.fill       = state == FILL;
    assign cache.fill_line  = rbuf;
    assign cache.invalidate = id_type == TYPE_FENCE_I && !cache.fill;

    assign arvalid = state == AR;
    assign rready  = state == R;
    assign arid    = FETCH_ID;
    assign arlen   = 8'd0;  // Single beat
    assign arburst = BURST_FIXED;
    assign araddr  = cacheable ? {pc[31:3], 3'b000} : pc[31:0];
    assign arsize  = cacheable ? SIZE_DWORD : SIZE_WORD;

    always_comb begin
        case (state)
            START:   ready = !go;  // Trap or stall answers at once
            FINISH:  ready = id_ready;
            default: ready = 1'b0;
        endcase
    end

    assign valid_out = (state == START && trap != TRAP_NONE) || state == FINISH;

    always_comb begin
        if (cacheable) begin
            inst = cache.hit_inst;
        end else begin
            inst = pc[2] ? rbuf[63:32] : rbuf[31:0];
        end
    end

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  fetch_pkg::addr_t           pc,
    input  logic [fetch_pkg::XLEN-1:0] mstatus,
    input  logic [fetch_pkg::XLEN-1:0] mie,
    input  logic [fetch_pkg::XLEN-1:0] mip,
    input  fetch_pkg::id_type_t        id_type,
    input  logic                       id_ready,
    output fetch_pkg::trap_t           trap,
    output logic                       valid_out,
    output logic                       ready,
    output fetch_pkg::inst_t           inst,
    input  logic                       arready,
    output logic                       arvalid,
    output logic [31:0]                araddr,
    output logic [3:0]                 arid,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    output logic                       rready,
    input  logic                       rvalid,
    input  axi_pkg::resp_t             rresp,
    input  fetch_pkg::line_t           rdata,
    input  logic                       rlast,
    input  logic [3:0]                 rid
);

    icache_if cache_bus ();  // Lookup and fill bundle

    fetch_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .mstatus  (mstatus),
        .mie      (mie),
        .mip      (mip),
        .id_type  (id_type),
        .id_ready (id_ready),
        .trap     (trap),
        .valid_out(valid_out),
        .ready    (ready),
        .inst     (inst),
        .arready  (arready),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .arid     (arid),
        .arlen    (arlen),
        .arsize   (arsize),
        .arburst  (arburst),
        .rready   (rready),
        .rvalid   (rvalid),
        .rresp    (rresp),
        .rdata    (rdata),
        .rlast    (rlast),
        .rid      (rid),
        .cache    (cache_bus.ctrl)
    );

    icache_tags u_tags (
        .clk  (clk),
        .rst  (rst),
        .cache(cache_bus.tags)
    );

    icache_data u_data (
        .clk  (clk),
        .rst  (rst),
        .cache(cache_bus.data)
    );

endmodule

// ==== bench/fetch_assertions.sv ====
module fetch_assertions (
    input logic        clk,
    input logic        rst,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rready,
    input logic        valid_out
);
    timeunit 1ns;
    timeprecision 100ps;

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before arready");

    no_valid_during_ar: assert property (@(posedge clk) disable iff (rst)
        !(valid_out && arvalid))
        else $error("valid_out and arvalid high in the same cycle");

    // Read phase only after the address phase
    rready_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(rready) |-> $past(arvalid && arready))
        else $error("rready raised without a completed address handshake");

endmodule

bind fetch_ctrl fetch_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rready   (rready),
    .valid_out(valid_out)
);

// ==== bench/fetch_tb.sv ====
module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;
    import axi_pkg::*;

    localparam int MAX_CYCLES = 300 * 40;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    addr_t       pc = '0;
    logic [63:0] mstatus = '0;
    logic [63:0] mie = '0;
    logic [63:0] mip = '0;
    id_type_t    id_type = TYPE_NOP;
    logic        id_ready = 1'b1;
    trap_t       trap;
    logic        valid_out;
    logic        ready;
    inst_t       inst;
    logic        arready = 1'b0;
    logic        arvalid;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rready;
    logic        rvalid = 1'b0;
    resp_t       rresp = RESP_OKAY;
    line_t       rdata = '0;
    logic        rlast = 1'b0;
    logic [3:0]  rid = '0;

    int unsigned         resp_delay;
    int unsigned         wait_cnt;
    int unsigned         ar_count;
    bit                  resp_stray;
    bit                  stray_left;
    logic [31:0]         last_araddr;
    logic [2:0]          last_arsize;
    logic [3:0]          last_arid;
    logic [7:0]          last_arlen;
    logic [1:0]          last_arburst;
    logic [NUM_WAYS-1:0] m_valid [NUM_SETS];
    tag_t                m_tag [NUM_SETS][NUM_WAYS];
    int                  cycle_cnt;
    int                  errors;
    int                  checks;
    int                  tests;

    fetch_unit DUT (.*);

    always #2 clk = ~clk;  // 4 ns period

    function automatic line_t mem_line(input logic [31:0] addr);
        logic [31:0] lo;
        lo = ({addr[31:3], 3'b000} * 32'h9e37_79b9) ^ 32'h1234_5678;
        return {~lo, lo};  // Words always differ
    endfunction

    function automatic bit predict_hit(input addr_t a);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[a[8:3]][w] && m_tag[a[8:3]][w] == a[63:9]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic void record_fill(input addr_t a);
        int victim;
        victim = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (victim < 0 && !m_valid[a[8:3]][w]) victim = w;
        end
        if (victim < 0) victim = 0;  // Full set
        m_valid[a[8:3]][victim] = 1'b1;
        m_tag[a[8:3]][victim]   = a[63:9];
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) $display("%s: passed", name);
        else $display("%s: failed with %0d errors", name, errors - errs_before);
    endtask

    // One fetch, bp cycles of id_ready low in FINISH
    task automatic run_fetch(input addr_t a, input int bp, output bit got_ar);
        int unsigned ar_before;
        int          cyc;
        bit          cached;
        bit          exp_hit;
        line_t       line;
        inst_t       exp_inst;
        inst_t       held;
        cached     = a[31:28] == 4'h8;
        exp_hit    = cached && predict_hit(a);
        line       = mem_line(a[31:0]);
        exp_inst   = a[2] ? line[63:32] : line[31:0];
        resp_delay = $urandom_range(0, 3);
        resp_stray = $urandom_range(0, 3) == 0;
        ar_before  = ar_count;
        cyc        = 0;
        @(posedge clk);
        pc       <= a;
        id_type  <= TYPE_NOP;
        mie      <= '0;
        mip      <= '0;
        mstatus  <= '0;
        id_ready <= bp == 0;
        @(negedge clk);
        while (!valid_out) begin
            cyc++;
            @(negedge clk);
        end
        got_ar = ar_count != ar_before;
        check("ar count", 64'(!exp_hit), 64'(ar_count - ar_before));
        if (exp_hit) check("hit latency", 64'd2, 64'(cyc));
        if (got_ar) begin
            check("araddr", cached ? 64'({a[31:3], 3'b000}) : 64'(a[31:0]), 64'(last_araddr));
            check("arsize", cached ? 64'(SIZE_DWORD) : 64'(SIZE_WORD), 64'(last_arsize));
            check("arid", 64'(FETCH_ID), 64'(last_arid));
            check("arlen", 64'd0, 64'(last_arlen));
            check("arburst", 64'(BURST_FIXED), 64'(last_arburst));
        end
        if (cached && !exp_hit) record_fill(a);
        held = inst;
        check("inst", 64'(exp_inst), 64'(inst));
        check("trap", 64'(TRAP_NONE), 64'(trap));
        check("ready", 64'(bp == 0), 64'(ready));
        for (int i = 1; i <= bp; i++) begin
            @(posedge clk);
            if (i == bp) id_ready <= 1'b1;
            @(negedge clk);
            check("held valid_out", 64'd1, 64'(valid_out));
            check("held inst", 64'(held), 64'(inst));
            check("held ready", 64'(i == bp), 64'(ready));
        end
    endtask

    task automatic raise_trap();
        addr_t       a;
        logic [63:0] csr_e;
        logic [63:0] csr_p;
        logic [63:0] csr_s;
        bit          timer_on;
        int unsigned ar_before;
        a     = {32'h0, $urandom};
        csr_e = {$urandom, $urandom};
        csr_p = {$urandom, $urandom};
        csr_s = {$urandom, $urandom};
        if ($urandom_range(0, 1) == 1) begin
            csr_e[MTIE_BIT] = 1'b1;
            csr_p[MTIP_BIT] = 1'b1;
            csr_s[MIE_BIT]  = 1'b1;
        end
        timer_on = csr_e[MTIE_BIT] && csr_p[MTIP_BIT] && csr_s[MIE_BIT];
        if (!timer_on && a[1:0] == 2'b00) a[1:0] = 2'b01;
        ar_before = ar_count;
        @(posedge clk);
        pc       <= a;
        mie      <= csr_e;
        mip      <= csr_p;
        mstatus  <= csr_s;
        id_type  <= TYPE_NOP;
        id_ready <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check("trap", timer_on ? 64'(TRAP_TIMER_INT) : 64'(TRAP_INST_MISALIGN), 64'(trap));
            check("trap valid_out", 64'd1, 64'(valid_out));
            check("trap ready", 64'd1, 64'(ready));
            check("trap arvalid", 64'd0, 64'(arvalid));
        end
        check("trap ar count", 64'd0, 64'(ar_count - ar_before));
    endtask

    task automatic send_fence();
        @(posedge clk);
        id_type <= TYPE_FENCE_I;
        @(negedge clk);
        check("fence ready", 64'd1, 64'(ready));
        check("fence valid_out", 64'd0, 64'(valid_out));
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s] = '0;
        end
    endtask

    // AXI slave with a random AR delay and an optional stray beat
    always @(posedge clk) begin
        if (rst) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            wait_cnt   <= 0;
            ar_count   <= 0;
            stray_left <= 1'b0;
        end else if (rvalid) begin
            if (rready && stray_left) begin
                stray_left <= 1'b0;
                rid        <= FETCH_ID;
                rdata      <= mem_line(last_araddr);
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end else if (arvalid && arready) begin
            arready      <= 1'b0;
            wait_cnt     <= 0;
            ar_count     <= ar_count + 1;
            last_araddr  <= araddr;
            last_arsize  <= arsize;
            last_arid    <= arid;
            last_arlen   <= arlen;
            last_arburst <= arburst;
            rvalid       <= 1'b1;
            rlast        <= 1'b1;
            rresp        <= RESP_OKAY;
            stray_left   <= resp_stray;
            rid          <= resp_stray ? 4'h9 : FETCH_ID;  // Wrong id first
            rdata        <= resp_stray ? ~mem_line(araddr) : mem_line(araddr);
        end else if (arvalid) begin
            if (wait_cnt >= resp_delay) arready <= 1'b1;
            else wait_cnt <= wait_cnt + 1;
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_cnt);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        addr_t a;
        bit    got_ar;
        int    errs_before;
        void'($urandom(32'he18f_1a33));
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        errs_before = errors;
        for (int i = 0; i < 40; i++) begin
            a = {32'h0, $urandom & 32'hffff_fffc};
            if (a[31:28] == 4'h8) a[31:28] = 4'h2;  // Outside the cached region
            run_fetch(a, 0, got_ar);
            check("uncached ar", 64'd1, 64'(got_ar));
        end
        report_test("uncached fetch", errs_before);

        errs_before = errors;
        for (int i = 0; i < 30; i++) begin
            a = {32'h0, 4'h8, 28'($urandom) & 28'hfff_fffc};
            run_fetch(a, 0, got_ar);
            run_fetch(a ^ 64'h4, 0, got_ar);
            check("second word ar", 64'd0, 64'(got_ar));
        end
        report_test("cached miss then hit", errs_before);

        errs_before = errors;
        send_fence();
        for (int k = 0; k < 9; k++) begin
            run_fetch({32'h0, 4'h8, 19'(k * 977 + 3), 6'h2a, 3'b000}, 0, got_ar);
            check("replace fill ar", 64'd1, 64'(got_ar));
        end
        for (int k = 0; k < 8; k++) begin
            run_fetch({32'h0, 4'h8, 19'(k * 977 + 3), 6'h2a, 3'b000}, 0, got_ar);
            check("refetch ar", 64'(k == 0), 64'(got_ar));
        end
        report_test("replacement", errs_before);

        errs_before = errors;
        for (int k = 0; k < 8; k++) begin
            run_fetch({32'h0, 4'h8, 19'(k * 131 + 7), 6'(k + 8), 3'b100}, 0, got_ar);
        end
        send_fence();
        for (int k = 0; k < 8; k++) begin
            run_fetch({32'h0, 4'h8, 19'(k * 131 + 7), 6'(k + 8), 3'b100}, 0, got_ar);
            check("after fence ar", 64'd1, 64'(got_ar));
        end
        report_test("fence.i", errs_before);

        errs_before = errors;
        for (int i = 0; i < 20; i++) begin
            raise_trap();
        end
        report_test("traps", errs_before);

        errs_before = errors;
        for (int i = 0; i < 30; i++) begin
            a = {32'h0, ($urandom_range(0, 1) == 1) ? 4'h8 : 4'h1, 28'($urandom) & 28'hfff_fffc};
            run_fetch(a, $urandom_range(0, 5), got_ar);
        end
        report_test("back-pressure", errs_before);

        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/fetch_pkg.sv
source/axi_pkg.sv
source/icache_if.sv
source/set_array.sv
source/icache_tags.sv
source/icache_data.sv
source/fetch_ctrl.sv
source/fetch_unit.sv
bench/fetch_assertions.sv
bench/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f sources.f -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null && exit 0 || exit 1
